// ==== sources.f ====
logic/soc_pkg.sv
logic/dev_bus_if.sv
logic/axil_target.sv
logic/region_router.sv
logic/dev_table.sv
logic/int_ctrl.sv
logic/main_ram.sv
logic/soc_top.sv
tests/tb_soc_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# Exits nonzero when the build fails or the run reports failure.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f sources.f \
	--top-module tb_soc_top -Mdir "$BUILD_DIR" -o tb_soc_top
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/tb_soc_top" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG_FILE"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "Everything OK" "$LOG_FILE"; then
	echo "simulation ended without reporting a result"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== tests/tb_soc_top.sv ====
//******************************
// testbench for soc_top
// drives the axi4-lite port and
// the irq sources, checks with
// assertions, ends on a watchdog
//******************************
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;
	localparam int CLK_PERIOD_NS = 10;
	localparam int RESET_CYCLES  = 8;
	localparam int RAM_WRITES    = 16;
	// handshakes plus the longest random hold for one access
	localparam int ACCESS_CYCLES = 16;
	localparam int ACCESS_COUNT  = 80;
	localparam int WATCHDOG_NS   =
		(RESET_CYCLES + ACCESS_COUNT * ACCESS_CYCLES + 200) * CLK_PERIOD_NS;

	logic        clk120mhz;
	logic        rst_p;
	logic [15:0] s_awaddr_i;
	logic        s_awvalid_i;
	logic        s_awready_o;
	logic [31:0] s_wdata_i;
	logic [3:0]  s_wstrb_i;
	logic        s_wvalid_i;
	logic        s_wready_o;
	logic [1:0]  s_bresp_o;
	logic        s_bvalid_o;
	logic        s_bready_i;
	logic [15:0] s_araddr_i;
	logic        s_arvalid_i;
	logic        s_arready_o;
	logic [31:0] s_rdata_o;
	logic [1:0]  s_rresp_o;
	logic        s_rvalid_o;
	logic        s_rready_i;
	logic [1:0]  irq_src_i;
	logic        irq_o;

	// words written to ram by byte address
	logic [31:0] ram_model [logic [15:0]];

	soc_top dut0 (.*);

	always #(CLK_PERIOD_NS / 2) clk120mhz = ~clk120mhz;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare_word(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected)
		else abort_run($sformatf("CHECK FAILED %s expected %h actual %h",
			name, expected, actual));
	endtask

	// inputs change 1 ns after the rising edge
	task automatic advance_cycle();
		@(posedge clk120mhz);
		#1;
	endtask

	// keeps the response waiting and offers reads and writes that must not be taken
	task automatic hold_response(input int hold);
		for (int i = 0; i < hold; i++) begin
			advance_cycle();
			s_awaddr_i  = 16'h4000;
			s_araddr_i  = 16'h0000;
			s_awvalid_i = i[0];
			s_wvalid_i  = i[0];
			s_arvalid_i = !i[0];
		end
		advance_cycle();
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		s_arvalid_i = 1'b0;
	endtask

	task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int hold;
		hold        = int'($urandom_range(0, 4));
		s_awaddr_i  = addr;
		s_wdata_i   = data;
		s_wstrb_i   = strb;
		s_awvalid_i = 1'b1;
		s_wvalid_i  = 1'b1;
		@(negedge clk120mhz);
		while (!s_awready_o)
			@(negedge clk120mhz);
		compare_word("s_wready_o", 32'(s_wready_o), 32'h1);
		advance_cycle();
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		@(negedge clk120mhz);
		while (!s_bvalid_o)
			@(negedge clk120mhz);
		compare_word("s_bresp_o", 32'(s_bresp_o), 32'h0);
		hold_response(hold);
		s_bready_i = 1'b1;
		advance_cycle();
		s_bready_i = 1'b0;
	endtask

	task automatic axil_read(input logic [15:0] addr, output logic [31:0] data);
		int hold;
		hold        = int'($urandom_range(0, 4));
		s_araddr_i  = addr;
		s_arvalid_i = 1'b1;
		@(negedge clk120mhz);
		while (!s_arready_o)
			@(negedge clk120mhz);
		advance_cycle();
		s_arvalid_i = 1'b0;
		@(negedge clk120mhz);
		while (!s_rvalid_o)
			@(negedge clk120mhz);
		compare_word("s_rresp_o", 32'(s_rresp_o), 32'h0);
		data = s_rdata_o;
		hold_response(hold);
		compare_word("s_rdata_o held", s_rdata_o, data);
		s_rready_i = 1'b1;
		advance_cycle();
		s_rready_i = 1'b0;
	endtask

	task automatic expect_read(input logic [15:0] addr, input logic [31:0] expected);
		logic [31:0] data;
		axil_read(addr, data);
		compare_word($sformatf("s_rdata_o at %h", addr), data, expected);
	endtask

	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		while (irq_o !== level && n < limit) begin
			advance_cycle();
			n++;
		end
		compare_word("irq_o", 32'(irq_o), 32'(level));
	endtask

	assert property (@(posedge clk120mhz) disable iff (rst_p)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o))
		else abort_run("read response dropped or changed while rready was low");

	assert property (@(posedge clk120mhz) disable iff (rst_p)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o)
		else abort_run("write response dropped while bready was low");

	// one access in flight and nothing new until the response is taken
	assert property (@(posedge clk120mhz) disable iff (rst_p)
		(s_bvalid_o || s_rvalid_o) |-> !(s_awready_o || s_wready_o || s_arready_o))
		else abort_run("new access accepted while a response was pending");

	assert property (@(posedge clk120mhz) disable iff (rst_p)
		(s_bresp_o == 2'b00) && (s_rresp_o == 2'b00))
		else abort_run("response code other than OKAY");

	initial begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		logic [15:0] addr;
		logic [31:0] word;
		void'($urandom(32'hb84e_04ee));
		clk120mhz   = 1'b0;
		rst_p       = 1'b1;
		s_awaddr_i  = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i   = '0;
		s_wstrb_i   = '0;
		s_wvalid_i  = 1'b0;
		s_bready_i  = 1'b0;
		s_araddr_i  = '0;
		s_arvalid_i = 1'b0;
		s_rready_i  = 1'b0;
		irq_src_i   = '0;
		repeat (RESET_CYCLES) @(posedge clk120mhz);
		#1;
		rst_p = 1'b0;
		advance_cycle();
		compare_word("{awready,wready,arready,bvalid,rvalid,irq_o}",
			32'({s_awready_o, s_wready_o, s_arready_o, s_bvalid_o, s_rvalid_o, irq_o}),
			32'h0);

		// directory ids and then map sizes
		expect_read(16'h0000, 32'h7);
		expect_read(16'h0004, 32'h3);
		expect_read(16'h0008, 32'h1);
		expect_read(16'h000c, 32'h0);
		expect_read(16'h0020, 32'h0000_0100);
		expect_read(16'h0024, 32'h0000_0100);
		expect_read(16'h0028, 32'h0000_1000);
		expect_read(16'h002c, 32'h0000_1000);

		for (int i = 0; i < RAM_WRITES; i++) begin
			addr = 16'h1000 | {4'h0, 10'($urandom_range(0, 1023)), 2'b00};
			word = $urandom();
			axil_write(addr, word, 4'hf);
			ram_model[addr] = word;
		end
		foreach (ram_model[a])
			expect_read(a, ram_model[a]);

		// bytes 0 and 2 strobed
		axil_write(16'h1000, 32'h1122_3344, 4'hf);
		axil_write(16'h1000, 32'haabb_ccdd, 4'b0101);
		ram_model[16'h1000] = 32'h11bb_33dd;
		expect_read(16'h1000, 32'h11bb_33dd);

		// unmapped region
		expect_read(16'h4000, 32'h0);
		axil_write(16'h4000, 32'hdead_beef, 4'hf);
		expect_read(16'h4000, 32'h0);
		expect_read(16'h1000, 32'h11bb_33dd);

		// source 1 enabled
		axil_write(16'h0104, 32'h2, 4'hf);
		irq_src_i = 2'b10;
		wait_irq(1'b1, 8);
		expect_read(16'h0100, 32'h2);
		axil_write(16'h0100, 32'h2, 4'hf);
		wait_irq(1'b0, 8);
		expect_read(16'h0100, 32'h0);
		// source 0 stays masked
		irq_src_i = 2'b11;
		repeat (4) advance_cycle();
		compare_word("irq_o", 32'(irq_o), 32'h0);
		expect_read(16'h0100, 32'h1);

		// warm reset clears the interrupt controller while ram keeps its words
		axil_write(16'h0104, 32'h3, 4'hf);
		wait_irq(1'b1, 8);
		axil_write(16'h0080, 32'h1, 4'hf);
		wait_irq(1'b0, 4);
		expect_read(16'h0100, 32'h0);
		expect_read(16'h0104, 32'h0);
		foreach (ram_model[a])
			expect_read(a, ram_model[a]);
		compare_word("irq_o", 32'(irq_o), 32'h0);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/soc_top.sv ====
//******************************
// top level, axi4-lite slave in
// front of the device table, the
// interrupt controller and ram
//******************************
`timescale 1ns/1ps
`default_nettype none

module soc_top (
	input  logic                              clk120mhz,
	input  logic                              rst_p,
	input  logic [soc_pkg::ADDR_W-1:0]        s_awaddr_i,
	input  logic                              s_awvalid_i,
	output logic                              s_awready_o,
	input  logic [soc_pkg::DATA_W-1:0]        s_wdata_i,
	input  logic [soc_pkg::STRB_W-1:0]        s_wstrb_i,
	input  logic                              s_wvalid_i,
	output logic                              s_wready_o,
	output logic [1:0]                        s_bresp_o,
	output logic                              s_bvalid_o,
	input  logic                              s_bready_i,
	input  logic [soc_pkg::ADDR_W-1:0]        s_araddr_i,
	input  logic                              s_arvalid_i,
	output logic                              s_arready_o,
	output logic [soc_pkg::DATA_W-1:0]        s_rdata_o,
	output logic [1:0]                        s_rresp_o,
	output logic                              s_rvalid_o,
	input  logic                              s_rready_i,
	input  logic [soc_pkg::IRQ_SRC_COUNT-1:0] irq_src_i,
	output logic                              irq_o
);
	logic soft_rst;

	dev_bus_if host_bus ();
	dev_bus_if devtbl_bus ();
	dev_bus_if intctrl_bus ();
	dev_bus_if ram_bus ();

	axil_target axil_target0 (
		.clk120mhz   (clk120mhz),   .rst_p       (rst_p),
		.s_awaddr_i  (s_awaddr_i),  .s_awvalid_i (s_awvalid_i), .s_awready_o (s_awready_o),
		.s_wdata_i   (s_wdata_i),   .s_wstrb_i   (s_wstrb_i),
		.s_wvalid_i  (s_wvalid_i),  .s_wready_o  (s_wready_o),
		.s_bresp_o   (s_bresp_o),   .s_bvalid_o  (s_bvalid_o),  .s_bready_i  (s_bready_i),
		.s_araddr_i  (s_araddr_i),  .s_arvalid_i (s_arvalid_i), .s_arready_o (s_arready_o),
		.s_rdata_o   (s_rdata_o),   .s_rresp_o   (s_rresp_o),
		.s_rvalid_o  (s_rvalid_o),  .s_rready_i  (s_rready_i),
		.bus_o       (host_bus.master)
	);

	region_router region_router0 (
		.clk120mhz (clk120mhz),
		.bus_i     (host_bus.device),
		.devtbl_o  (devtbl_bus.master),
		.intctrl_o (intctrl_bus.master),
		.ram_o     (ram_bus.master)
	);

	dev_table dev_table0 (
		.clk120mhz  (clk120mhz),
		.rst_p      (rst_p),
		.bus_i      (devtbl_bus.device),
		.soft_rst_o (soft_rst)
	);

	// follows the warm reset, not only the pin
	int_ctrl int_ctrl0 (
		.clk120mhz  (clk120mhz),
		.soft_rst_i (soft_rst),
		.bus_i      (intctrl_bus.device),
		.irq_src_i  (irq_src_i),
		.irq_o      (irq_o)
	);

	main_ram main_ram0 (
		.clk120mhz (clk120mhz),
		.bus_i     (ram_bus.device)
	);

endmodule

`default_nettype wire

// ==== logic/main_ram.sv ====
//******************************
// on-chip word ram, byte strobe
// writes, ack in second cycle
//******************************
`timescale 1ns/1ps
`default_nettype none

module main_ram (
	input  logic      clk120mhz,
	dev_bus_if.device bus_i
);
	import soc_pkg::*;

	logic [DATA_W-1:0]                     mem [RAM_MAPSZ / STRB_W];
	logic [$clog2(RAM_MAPSZ / STRB_W)-1:0] idx;
	logic [DATA_W-1:0]                     rdata_q;
	logic                                  ack_q;

	assign idx = bus_i.addr[$clog2(RAM_MAPSZ / STRB_W)-1:0];

	always_ff @(posedge clk120mhz) begin
		// ack drops again so each request is acked once
		ack_q   <= (bus_i.op != OP_IDLE) && !ack_q;
		rdata_q <= mem[idx];
		if (bus_i.op == OP_WRITE && !ack_q) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (bus_i.sel[b])
					mem[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
			end
		end
	end

	assign bus_i.rdata = rdata_q;
	assign bus_i.rdy   = ack_q;

endmodule

`default_nettype wire

// ==== logic/int_ctrl.sv ====
//******************************
// interrupt controller, two
// edge sources, one destination
// pending at 0, enable mask at 4
//******************************
`timescale 1ns/1ps
`default_nettype none

module int_ctrl (
	input  logic                              clk120mhz,
	input  logic                              soft_rst_i,
	dev_bus_if.device                         bus_i,
	input  logic [soc_pkg::IRQ_SRC_COUNT-1:0] irq_src_i,
	output logic                              irq_o
);
	import soc_pkg::*;

	logic [IRQ_SRC_COUNT-1:0] src_q;
	logic [IRQ_SRC_COUNT-1:0] rise;
	logic [IRQ_SRC_COUNT-1:0] pending;
	logic [IRQ_SRC_COUNT-1:0] enable;
	logic [IRQ_SRC_COUNT-1:0] clr;
	logic                     wr_pend;
	logic                     wr_en;

	assign rise    = irq_src_i & ~src_q;
	assign wr_pend = (bus_i.op == OP_WRITE) && (bus_i.addr == '0) && bus_i.sel[0];
	assign wr_en   = (bus_i.op == OP_WRITE) && (bus_i.addr == WORD_ADDR_W'(1)) && bus_i.sel[0];
	assign clr     = wr_pend ? bus_i.wdata[IRQ_SRC_COUNT-1:0] : '0;

	always_ff @(posedge clk120mhz) begin
		src_q <= irq_src_i;
		if (soft_rst_i) begin
			pending <= '0;
			enable  <= '0;
			irq_o   <= 1'b0;
		end else begin
			// a new edge beats a clear of the same bit
			pending <= (pending & ~clr) | rise;
			if (wr_en)
				enable <= bus_i.wdata[IRQ_SRC_COUNT-1:0];
			irq_o <= |(pending & enable);
		end
	end

	assign bus_i.rdata = (bus_i.addr == '0) ? DATA_W'(pending) :
		(bus_i.addr == WORD_ADDR_W'(1)) ? DATA_W'(enable) : '0;
	assign bus_i.rdy   = (bus_i.op != OP_IDLE);

	assert property (@(posedge clk120mhz) soft_rst_i |=> !irq_o)
		else $error("interrupt raised during soft reset");

endmodule

`default_nettype wire

// ==== logic/dev_table.sv ====
//******************************
// read-only device directory with
// the warm-reset control register
// soft_rst_o resets the devices
// that follow software reset
//******************************
`timescale 1ns/1ps
`default_nettype none

module dev_table (
	input  logic      clk120mhz,
	input  logic      rst_p,
	dev_bus_if.device bus_i,
	output logic      soft_rst_o
);
	import soc_pkg::*;

	logic [ADDR_W-1:0]     byte_off;
	logic [RST_CNTR_W-1:0] rst_cntr;
	logic                  ctrl_wr;

	assign byte_off = {bus_i.addr, 2'b00};

	// ids at 4*k, map sizes at 0x20 + 4*k, everything else zero
	always_comb begin
		case (byte_off)
			ADDR_W'(4 * REGION_DEVTBL):
				bus_i.rdata = DATA_W'(DEVID_DEVTBL);
			ADDR_W'(4 * REGION_INTCTRL):
				bus_i.rdata = DATA_W'(DEVID_INTCTRL);
			ADDR_W'(4 * REGION_RAM):
				bus_i.rdata = DATA_W'(DEVID_RAM);
			ADDR_W'(4 * REGION_INVALID):
				bus_i.rdata = DATA_W'(DEVID_INVALID);
			ADDR_W'(32'h20 + 4 * REGION_DEVTBL):
				bus_i.rdata = DATA_W'(DEVTBL_MAPSZ);
			ADDR_W'(32'h20 + 4 * REGION_INTCTRL):
				bus_i.rdata = DATA_W'(INTCTRL_MAPSZ);
			ADDR_W'(32'h20 + 4 * REGION_RAM):
				bus_i.rdata = DATA_W'(RAM_MAPSZ);
			ADDR_W'(32'h20 + 4 * REGION_INVALID):
				bus_i.rdata = DATA_W'(INVALID_MAPSZ);
			default:
				bus_i.rdata = '0;
		endcase
	end

	assign bus_i.rdy = (bus_i.op != OP_IDLE);

	// bit 0 of the control register requests a warm reset
	assign ctrl_wr = (bus_i.op == OP_WRITE) && (byte_off == ADDR_W'(RST_CTRL_OFFSET)) &&
		bus_i.sel[0] && bus_i.wdata[0];

	// loads all ones, so soft reset lasts 15 cycles after release
	always_ff @(posedge clk120mhz) begin
		if (rst_p || ctrl_wr) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	assign soft_rst_o = (rst_cntr != '0);

endmodule

`default_nettype wire

// ==== logic/region_router.sv ====
//******************************
// address decoder for the device
// bus, forwards each request to
// one region and returns its
// data and ready
//******************************
`timescale 1ns/1ps
`default_nettype none

module region_router (
	input  logic       clk120mhz,
	dev_bus_if.device  bus_i,
	dev_bus_if.master  devtbl_o,
	dev_bus_if.master  intctrl_o,
	dev_bus_if.master  ram_o
);
	import soc_pkg::*;

	logic [REGION_COUNT-1:0] hit;

	function automatic logic in_region(input logic [WORD_ADDR_W-1:0] waddr,
		input logic [ADDR_W-1:0] base, input logic [ADDR_W-1:0] size);
		logic [ADDR_W-1:0] baddr;
		baddr = {waddr, 2'b00};
		return (baddr >= base) && (baddr < base + size);
	endfunction

	always_comb begin
		hit = '0;
		hit[REGION_DEVTBL]  = in_region(bus_i.addr, DEVTBL_BASE, DEVTBL_MAPSZ);
		hit[REGION_INTCTRL] = in_region(bus_i.addr, INTCTRL_BASE, INTCTRL_MAPSZ);
		hit[REGION_RAM]     = in_region(bus_i.addr, RAM_BASE, RAM_MAPSZ);
		hit[REGION_INVALID] = !(hit[REGION_DEVTBL] || hit[REGION_INTCTRL] || hit[REGION_RAM]);
	end

	// devices see addresses relative to their own base
	assign devtbl_o.op     = hit[REGION_DEVTBL] ? bus_i.op : OP_IDLE;
	assign devtbl_o.addr   = bus_i.addr - WORD_ADDR_W'(DEVTBL_BASE >> 2);
	assign devtbl_o.wdata  = bus_i.wdata;
	assign devtbl_o.sel    = bus_i.sel;

	assign intctrl_o.op    = hit[REGION_INTCTRL] ? bus_i.op : OP_IDLE;
	assign intctrl_o.addr  = bus_i.addr - WORD_ADDR_W'(INTCTRL_BASE >> 2);
	assign intctrl_o.wdata = bus_i.wdata;
	assign intctrl_o.sel   = bus_i.sel;

	assign ram_o.op        = hit[REGION_RAM] ? bus_i.op : OP_IDLE;
	assign ram_o.addr      = bus_i.addr - WORD_ADDR_W'(RAM_BASE >> 2);
	assign ram_o.wdata     = bus_i.wdata;
	assign ram_o.sel       = bus_i.sel;

	always_comb begin
		bus_i.rdata = '0;
		bus_i.rdy   = 1'b0;
		if (hit[REGION_DEVTBL]) begin
			bus_i.rdata = devtbl_o.rdata;
			bus_i.rdy   = devtbl_o.rdy;
		end else if (hit[REGION_INTCTRL]) begin
			bus_i.rdata = intctrl_o.rdata;
			bus_i.rdy   = intctrl_o.rdy;
		end else if (hit[REGION_RAM]) begin
			bus_i.rdata = ram_o.rdata;
			bus_i.rdy   = ram_o.rdy;
		end else if (hit[REGION_INVALID]) begin
			// unmapped accesses read zero and complete at once
			bus_i.rdy   = (bus_i.op != OP_IDLE);
		end
	end

	assert property (@(posedge clk120mhz)
		$onehot0({devtbl_o.op != OP_IDLE, intctrl_o.op != OP_IDLE, ram_o.op != OP_IDLE}))
		else $error("more than one device selected");

endmodule

`default_nettype wire

// ==== logic/axil_target.sv ====
//******************************
// axi4-lite slave front end
// accepts one access at a time
// and replays it on the device
// bus, holding the response
//******************************
`timescale 1ns/1ps
`default_nettype none

module axil_target (
	input  logic                       clk120mhz,
	input  logic                       rst_p,
	input  logic [soc_pkg::ADDR_W-1:0] s_awaddr_i,
	input  logic                       s_awvalid_i,
	output logic                       s_awready_o,
	input  logic [soc_pkg::DATA_W-1:0] s_wdata_i,
	input  logic [soc_pkg::STRB_W-1:0] s_wstrb_i,
	input  logic                       s_wvalid_i,
	output logic                       s_wready_o,
	output logic [1:0]                 s_bresp_o,
	output logic                       s_bvalid_o,
	input  logic                       s_bready_i,
	input  logic [soc_pkg::ADDR_W-1:0] s_araddr_i,
	input  logic                       s_arvalid_i,
	output logic                       s_arready_o,
	output logic [soc_pkg::DATA_W-1:0] s_rdata_o,
	output logic [1:0]                 s_rresp_o,
	output logic                       s_rvalid_o,
	input  logic                       s_rready_i,
	dev_bus_if.master                  bus_o
);
	import soc_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RESP} state_t;

	state_t                 state;
	logic                   is_write_q;
	logic [WORD_ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0]      wdata_q;
	logic [STRB_W-1:0]      strb_q;
	logic [DATA_W-1:0]      rdata_q;
	logic                   wr_acc;
	logic                   rd_acc;

	// a write wins, a read waits while any write channel is offered
	assign wr_acc = (state == ST_IDLE) && s_awvalid_i && s_wvalid_i;
	assign rd_acc = (state == ST_IDLE) && s_arvalid_i && !s_awvalid_i && !s_wvalid_i;

	assign s_awready_o = wr_acc;
	assign s_wready_o  = wr_acc;
	assign s_arready_o = rd_acc;

	always_ff @(posedge clk120mhz) begin
		if (rst_p) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: if (wr_acc || rd_acc) state <= ST_REQ;
				ST_REQ:  if (bus_o.rdy) state <= ST_RESP;
				ST_RESP: if (is_write_q ? s_bready_i : s_rready_i) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk120mhz) begin
		if (wr_acc) begin
			is_write_q <= 1'b1;
			addr_q     <= s_awaddr_i[ADDR_W-1:2];
			wdata_q    <= s_wdata_i;
			strb_q     <= s_wstrb_i;
		end else if (rd_acc) begin
			is_write_q <= 1'b0;
			addr_q     <= s_araddr_i[ADDR_W-1:2];
			wdata_q    <= '0;
			strb_q     <= '1;
		end
		// read data is sampled in the completing cycle
		if (state == ST_REQ && bus_o.rdy)
			rdata_q <= is_write_q ? '0 : bus_o.rdata;
	end

	always_comb begin
		bus_o.op = OP_IDLE;
		if (state == ST_REQ)
			bus_o.op = is_write_q ? OP_WRITE : OP_READ;
	end

	assign bus_o.addr  = addr_q;
	assign bus_o.wdata = wdata_q;
	assign bus_o.sel   = strb_q;

	assign s_bvalid_o = (state == ST_RESP) && is_write_q;
	assign s_rvalid_o = (state == ST_RESP) && !is_write_q;
	assign s_rdata_o  = rdata_q;
	assign s_bresp_o  = 2'b00;
	assign s_rresp_o  = 2'b00;

	assert property (@(posedge clk120mhz) disable iff (rst_p) !(s_bvalid_o && s_rvalid_o))
		else $error("write and read responses valid together");

	// a response held back by the master must not move
	assert property (@(posedge clk120mhz) disable iff (rst_p)
		(s_bvalid_o && !s_bready_i) || (s_rvalid_o && !s_rready_i) |=>
		$stable({s_bvalid_o, s_rvalid_o, s_rdata_o, s_bresp_o, s_rresp_o}))
		else $error("response changed before it was taken");

endmodule

`default_nettype wire

// ==== logic/dev_bus_if.sv ====
//******************************
// op/ready request bus between
// the front end, the router and
// the devices
//******************************
`timescale 1ns/1ps
`default_nettype none

interface dev_bus_if;
	import soc_pkg::*;

	dev_op_t                op;
	logic [WORD_ADDR_W-1:0] addr;
	logic [DATA_W-1:0]      wdata;
	logic [STRB_W-1:0]      sel;
	logic [DATA_W-1:0]      rdata;
	logic                   rdy;

	// master holds op and fields until rdy, then idles for a cycle
	modport master (
		output op, addr, wdata, sel,
		input  rdata, rdy
	);

	modport device (
		input  op, addr, wdata, sel,
		output rdata, rdy
	);
endinterface

`default_nettype wire

// ==== logic/soc_pkg.sv ====
//******************************
// shared bus widths, memory map,
// device ids and reset constants
// imported by every rtl module
//******************************
`default_nettype none

package soc_pkg;

	// bus geometry
	localparam int DATA_W      = 32;
	localparam int ADDR_W      = 16;
	localparam int WORD_ADDR_W = 14;
	localparam int STRB_W      = 4;

	// op codes follow the peripheral interconnect encoding
	typedef enum logic [1:0] {
		OP_IDLE  = 2'b00,
		OP_READ  = 2'b10,
		OP_WRITE = 2'b01
	} dev_op_t;

	// region indices, the last one catches unmapped accesses
	localparam int REGION_DEVTBL  = 0;
	localparam int REGION_INTCTRL = 1;
	localparam int REGION_RAM     = 2;
	localparam int REGION_INVALID = 3;
	localparam int REGION_COUNT   = 4;

	localparam logic [ADDR_W-1:0] DEVTBL_BASE   = 16'h0000;
	localparam logic [ADDR_W-1:0] DEVTBL_MAPSZ  = 16'h0100;
	localparam logic [ADDR_W-1:0] INTCTRL_BASE  = 16'h0100;
	localparam logic [ADDR_W-1:0] INTCTRL_MAPSZ = 16'h0100;
	localparam logic [ADDR_W-1:0] RAM_BASE      = 16'h1000;
	localparam logic [ADDR_W-1:0] RAM_MAPSZ     = 16'h1000;
	localparam logic [ADDR_W-1:0] INVALID_MAPSZ = 16'h1000;

	localparam int DEVID_DEVTBL  = 7;
	localparam int DEVID_INTCTRL = 3;
	localparam int DEVID_RAM     = 1;
	localparam int DEVID_INVALID = 0;

	localparam int IRQ_SRC_COUNT = 2;

	// warm reset
	localparam int         RST_CNTR_W      = 4;
	localparam logic [7:0] RST_CTRL_OFFSET = 8'h80;

endpackage

`default_nettype wire
